// File: files.f
+incdir+hdl
hdl/rvCorePkg.sv
hdl/instrDecoder.sv
hdl/registerFile.sv
hdl/aluUnit.sv
hdl/coreControl.sv
hdl/femtoCore.sv
testbench/tbMemory.sv
testbench/tbCore.sv

// File: hdl/aluUnit.sv
module aluUnit (
   input  logic        clk,
   input  logic        aluStart,    // one cycle pulse from EXECUTE1
   input  logic        isAlu,       // ALUIMM or ALUREG, else branch compare
   input  logic [31:0] in1,
   input  logic [31:0] in2,
   input  logic [2:0]  funct3,
   input  logic        subtract,
   input  logic        arithShift,
   output logic [31:0] aluOut,
   output logic        predicate,
   output logic        aluBusy
);

   logic [31:0] result;      // alu result, also the shift register
   logic [4:0]  shiftCount;  // shift steps still to do
   logic [31:0] sum;
   logic [32:0] diff;        // in1 - in2, bit 32 is the borrow
   logic        lt;
   logic        ltu;
   logic        eq;

   assign aluOut  = result;
   assign aluBusy = |shiftCount;

   // ************************************************************
   // one adder and one 33 bit subtractor serve every op and compare
   // ************************************************************
   assign sum  = in1 + in2;
   assign diff = {1'b1, ~in2} + {1'b0, in1} + 33'd1;
   assign ltu  = diff[32];
   assign lt   = (in1[31] ^ in2[31]) ? in1[31] : diff[32];  // signs differ, in1 sign decides
   assign eq   = (diff[31:0] == 32'h0);

   always_ff @(posedge clk) begin
      if (aluStart && isAlu) begin
         case (funct3)
            3'b000: result <= subtract ? diff[31:0] : sum;  // ADD / SUB
            3'b010: result <= {31'b0, lt};                  // SLT
            3'b011: result <= {31'b0, ltu};                 // SLTU
            3'b100: result <= in1 ^ in2;                    // XOR
            3'b110: result <= in1 | in2;                    // OR
            3'b111: result <= in1 & in2;                    // AND
            default: begin                                  // SLL, SRL, SRA
               result     <= in1;
               shiftCount <= in2[4:0];
            end
         endcase
      end else if (shiftCount != 5'd0) begin
         // one bit per cycle
         // funct3[2] set: right shift, sign fill only for SRA
         shiftCount <= shiftCount - 5'd1;
         result     <= funct3[2] ? {arithShift & result[31], result[31:1]}
                                 : {result[30:0], 1'b0};
      end else begin
         shiftCount <= 5'd0;  // idle, counter parks at zero
      end
   end

   // branch condition, used by EXECUTE2 one cycle later
   always_ff @(posedge clk) begin
      if (aluStart && !isAlu) begin
         case (funct3)
            3'b000:  predicate <= eq;    // BEQ
            3'b001:  predicate <= !eq;   // BNE
            3'b100:  predicate <= lt;    // BLT
            3'b101:  predicate <= !lt;   // BGE
            3'b110:  predicate <= ltu;   // BLTU
            3'b111:  predicate <= !ltu;  // BGEU
            default: predicate <= 1'b0;  // not a branch encoding
         endcase
      end
   end

endmodule

// File: hdl/coreConfig_config.svh
`ifndef CORECONFIG_CONFIG_SVH
`define CORECONFIG_CONFIG_SVH

// ************************************************************
// core build options
// ************************************************************

// address of the first fetch once reset is released
`define RESET_ADDR 32'h0000_0000

// bits kept in pc and address registers, upper bus bits read as zero
`define ADDR_WIDTH 16

// general purpose registers, x0 included
`define NUM_REGS 32

`endif

// File: hdl/coreControl.sv
`include "coreConfig_config.svh"

module coreControl (
   input  logic                     clk,
   input  logic                     reset,
   input  logic [31:0]              rdata,
   input  logic                     rbusy,
   input  logic                     wbusy,
   output rvCorePkg::memReq_t       memReq,
   output logic [31:0]              instrWord,
   input  rvCorePkg::decodedInstr_t dec,
   input  logic [31:0]              rs1Data,
   input  logic [31:0]              rs2Data,
   input  logic [31:0]              aluOut,
   input  logic                     predicate,
   input  logic                     aluBusy,
   output logic                     aluStart,
   output logic                     regReadEn,
   output logic                     wbEn,
   output logic [4:0]               wbRd,
   output logic [31:0]              wbData
);
   import rvCorePkg::*;

   localparam int          AW       = `ADDR_WIDTH;
   localparam logic [31:0] RESET_PC = `RESET_ADDR;

   coreState_t    state;
   logic [31:0]   instrReg;      // latched instruction word
   logic [AW-1:0] pc;
   logic [AW-1:0] addrReg;       // drives the memory address
   logic [31:0]   computedAddr;  // rs1/pc + imm, full width for AUIPC
   logic          wbPending;     // rd still owed a value in WAITDONE

   logic          isLoad;
   logic          isStore;
   logic          isAlu;
   logic          isJalr;
   logic          jumpOrTaken;
   logic          waitDone;
   logic [AW-1:0] pcPlus4;
   logic [AW-1:0] nextPc;
   logic [31:0]   rs1OrPc;

   assign isLoad  = (dec.opClass == LOAD);
   assign isStore = (dec.opClass == STORE);
   assign isAlu   = (dec.opClass == ALUIMM) | (dec.opClass == ALUREG);
   assign isJalr  = (dec.opClass == JALR);

   assign jumpOrTaken = (dec.opClass == JAL) | isJalr | ((dec.opClass == BRANCH) & predicate);
   assign waitDone    = !aluBusy & !rbusy & !wbusy;  // shifter and memory both idle

   // ************************************************************
   // address and pc arithmetic
   // ************************************************************
   assign pcPlus4 = pc + AW'(4);
   assign rs1OrPc = (isLoad | isStore | isJalr) ? rs1Data : 32'(pc);
   // jump targets drop bit 0 as JALR requires
   assign nextPc  = jumpOrTaken ? {computedAddr[AW-1:1], 1'b0} : pcPlus4;

   // ************************************************************
   // control FSM
   // ************************************************************
   always_ff @(posedge clk) begin
      if (!reset) begin
         state     <= WAITDONE;  // waits for memory, then fetches from pc
         pc        <= RESET_PC[AW-1:0];
         wbPending <= 1'b0;
      end else begin
         case (state)
            FETCH:     state <= WAITINSTR;
            WAITINSTR: if (!rbusy) state <= EXECUTE1;  // instruction word on rdata
            EXECUTE1:  state <= EXECUTE2;
            EXECUTE2: begin
               pc        <= nextPc;
               wbPending <= dec.wbEnable;
               if (isLoad)                 state <= LOADSTEP;
               else if (isStore)           state <= STORESTEP;
               else if (isAlu && aluBusy)  state <= WAITDONE;   // shift in progress
               else                        state <= FETCH;
            end
            LOADSTEP:  state <= WAITDONE;
            STORESTEP: state <= WAITDONE;
            WAITDONE:  if (waitDone) state <= FETCH;
            default:   state <= WAITDONE;
         endcase
      end
   end

   // payload registers
   always_ff @(posedge clk) begin
      if (state == WAITINSTR && !rbusy) begin
         instrReg <= rdata;
      end
      if (state == EXECUTE1) begin
         computedAddr <= rs1OrPc + dec.addrImm;
      end
      if (state == EXECUTE2) begin
         addrReg <= (isLoad | isStore) ? computedAddr[AW-1:0] : nextPc;  // data or fetch address
      end else if (state == WAITDONE && waitDone) begin
         addrReg <= pc;  // back to the fetch address
      end
   end

   // ************************************************************
   // outputs
   // ************************************************************
   assign instrWord = instrReg;
   assign regReadEn = (state == WAITINSTR) & !rbusy;  // source fields come straight off rdata
   assign aluStart  = (state == EXECUTE1);

   assign memReq.addr  = 32'(addrReg);      // upper bits zero
   assign memReq.wdata = rs2Data;
   assign memReq.wmask = {4{state == STORESTEP}};  // word stores only
   assign memReq.rstrb = (state == FETCH) | (state == LOADSTEP);

   // loads and shifts finish in WAITDONE, the rest in EXECUTE2
   assign wbEn = ((state == EXECUTE2) & dec.wbEnable & !isLoad) |
                 ((state == WAITDONE) & wbPending & waitDone);
   assign wbRd = dec.rd;

   always_comb begin
      case (dec.opClass)
         LUI:       wbData = dec.uImm;
         AUIPC:     wbData = computedAddr;  // pc + uImm
         JAL, JALR: wbData = 32'(pcPlus4);  // return address
         LOAD:      wbData = rdata;
         default:   wbData = aluOut;
      endcase
   end

endmodule

// File: hdl/femtoCore.sv
module femtoCore (
   input  logic               clk,
   input  logic               reset,
   output rvCorePkg::memReq_t memReq,
   input  logic [31:0]        rdata,
   input  logic               rbusy,
   input  logic               wbusy
);
   import rvCorePkg::*;

   decodedInstr_t dec;
   logic [31:0]   instrWord;
   logic [31:0]   rs1Data;
   logic [31:0]   rs2Data;
   logic [31:0]   aluIn2;
   logic [31:0]   aluOut;
   logic [31:0]   wbData;
   logic [4:0]    wbRd;
   logic          predicate;
   logic          aluBusy;
   logic          aluStart;
   logic          isAlu;
   logic          regReadEn;
   logic          wbEn;

   assign isAlu  = (dec.opClass == ALUIMM) | (dec.opClass == ALUREG);
   assign aluIn2 = dec.useRs2 ? rs2Data : dec.iImm;  // reg-reg and branches use rs2

   coreControl control (
      .clk(clk), .reset(reset),
      .rdata(rdata), .rbusy(rbusy), .wbusy(wbusy), .memReq(memReq),
      .instrWord(instrWord), .dec(dec),
      .rs1Data(rs1Data), .rs2Data(rs2Data),
      .aluOut(aluOut), .predicate(predicate), .aluBusy(aluBusy), .aluStart(aluStart),
      .regReadEn(regReadEn), .wbEn(wbEn), .wbRd(wbRd), .wbData(wbData)
   );

   instrDecoder decoder (.instrWord(instrWord), .dec(dec));

   // source indices taken off the bus while the instruction arrives
   registerFile regFile (
      .clk(clk), .readEn(regReadEn),
      .rs1Idx(rdata[19:15]), .rs2Idx(rdata[24:20]),
      .rs1Data(rs1Data), .rs2Data(rs2Data),
      .writeEn(wbEn), .rd(wbRd), .writeData(wbData)
   );

   aluUnit alu (
      .clk(clk), .aluStart(aluStart), .isAlu(isAlu),
      .in1(rs1Data), .in2(aluIn2), .funct3(dec.funct3),
      .subtract(dec.subtract), .arithShift(dec.arithShift),
      .aluOut(aluOut), .predicate(predicate), .aluBusy(aluBusy)
   );

endmodule

// File: hdl/instrDecoder.sv
module instrDecoder (
   input  logic [31:0]              instrWord,
   output rvCorePkg::decodedInstr_t dec
);
   import rvCorePkg::*;

   opClass_t    opClass;
   logic [31:0] iImm;
   logic [31:0] sImm;
   logic [31:0] bImm;
   logic [31:0] uImm;
   logic [31:0] jImm;

   // ************************************************************
   // the five immediate formats
   // ************************************************************
   assign iImm = {{21{instrWord[31]}}, instrWord[30:20]};
   assign sImm = {{21{instrWord[31]}}, instrWord[30:25], instrWord[11:7]};
   assign bImm = {{20{instrWord[31]}}, instrWord[7], instrWord[30:25],
                  instrWord[11:8], 1'b0};
   assign uImm = {instrWord[31:12], 12'b0};
   assign jImm = {{12{instrWord[31]}}, instrWord[19:12], instrWord[20],
                  instrWord[30:21], 1'b0};

   // opcode class, the two lsbs are always 11 in RV32I and not checked
   always_comb begin
      case (instrWord[6:2])
         5'b00000: opClass = LOAD;
         5'b00100: opClass = ALUIMM;
         5'b00101: opClass = AUIPC;
         5'b01000: opClass = STORE;
         5'b01100: opClass = ALUREG;
         5'b01101: opClass = LUI;
         5'b11000: opClass = BRANCH;
         5'b11001: opClass = JALR;
         5'b11011: opClass = JAL;
         default:  opClass = ILLEGAL;
      endcase
   end

   always_comb begin
      dec.opClass    = opClass;
      dec.rd         = instrWord[11:7];
      dec.funct3     = instrWord[14:12];
      dec.subtract   = instrWord[30] & instrWord[5];  // bit 5 tells SUB from ADDI
      dec.arithShift = instrWord[30];
      dec.useRs2     = (opClass == ALUREG) | (opClass == BRANCH);
      // no rd for branch and store, illegal words leave the regs alone
      dec.wbEnable   = (opClass != BRANCH) & (opClass != STORE) & (opClass != ILLEGAL);
      dec.iImm       = iImm;
      dec.uImm       = uImm;

      // offset for rs1/pc + imm, loads and JALR fall through to iImm
      case (opClass)
         JAL:     dec.addrImm = jImm;
         AUIPC:   dec.addrImm = uImm;
         STORE:   dec.addrImm = sImm;
         BRANCH:  dec.addrImm = bImm;
         default: dec.addrImm = iImm;
      endcase
   end

endmodule

// File: hdl/registerFile.sv
`include "coreConfig_config.svh"

module registerFile (
   input  logic                          clk,
   input  logic                          readEn,
   input  logic [$clog2(`NUM_REGS)-1:0]  rs1Idx,
   input  logic [$clog2(`NUM_REGS)-1:0]  rs2Idx,
   output logic [31:0]                   rs1Data,
   output logic [31:0]                   rs2Data,
   input  logic                          writeEn,
   input  logic [$clog2(`NUM_REGS)-1:0]  rd,
   input  logic [31:0]                   writeData
);

   logic [31:0] regs [`NUM_REGS];

   // both ports latch together while the instruction arrives
   always_ff @(posedge clk) begin
      if (readEn) begin
         rs1Data <= (rs1Idx == '0) ? 32'h0 : regs[rs1Idx];  // x0 reads as zero
         rs2Data <= (rs2Idx == '0) ? 32'h0 : regs[rs2Idx];
      end
   end

   always_ff @(posedge clk) begin
      if (writeEn && (rd != '0)) begin  // x0 is never written
         regs[rd] <= writeData;
      end
   end

endmodule

// File: hdl/rvCorePkg.sv
package rvCorePkg;

   // ************************************************************
   // instruction classes, from opcode bits 6..2
   // ************************************************************
   typedef enum logic [3:0] {
      LOAD,      // rd <- mem[rs1 + iImm]
      ALUIMM,    // rd <- rs1 op iImm
      AUIPC,     // rd <- pc + uImm
      STORE,     // mem[rs1 + sImm] <- rs2
      ALUREG,    // rd <- rs1 op rs2
      LUI,       // rd <- uImm
      BRANCH,    // if (rs1 op rs2) pc <- pc + bImm
      JALR,      // rd <- pc + 4, pc <- rs1 + iImm
      JAL,       // rd <- pc + 4, pc <- pc + jImm
      ILLEGAL    // anything else, executed as a no-op
   } opClass_t;

   // everything the datapath needs from one instruction word
   typedef struct packed {
      opClass_t    opClass;
      logic [4:0]  rd;
      logic [2:0]  funct3;
      logic        subtract;    // SUB only, ADDI never subtracts
      logic        arithShift;  // SRA / SRAI
      logic        useRs2;      // alu operand 2 from rs2, else iImm
      logic        wbEnable;    // instruction writes rd
      logic [31:0] addrImm;     // offset for the address adder
      logic [31:0] iImm;
      logic [31:0] uImm;
   } decodedInstr_t;

   // memory port toward the outside world
   typedef struct packed {
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [3:0]  wmask;   // nonzero for exactly one cycle per store
      logic        rstrb;   // starts a read
   } memReq_t;

   // ************************************************************
   // control FSM, one hot
   // ************************************************************
   typedef enum logic [6:0] {
      FETCH     = 7'b000_0001,
      WAITINSTR = 7'b000_0010,
      EXECUTE1  = 7'b000_0100,
      EXECUTE2  = 7'b000_1000,
      LOADSTEP  = 7'b001_0000,
      STORESTEP = 7'b010_0000,
      WAITDONE  = 7'b100_0000
   } coreState_t;

endpackage

// File: testbench/program.hex
// hand-assembled RV32I words, one instruction per word, address order from 0
// comment gives the word address and the instructions on that line
00300113 FFB00093 7AD00F13   // 000 addi x2,3 / addi x1,-5 / addi x30,0x7ad poison
002081B3 20302023            // 00c add x3,x1,x2 / sw x3,0x200
402081B3 20302223            // 014 sub / sw 0x204
0020A1B3 20302423            // 01c slt / sw 0x208
0020B1B3 20302623            // 024 sltu / sw 0x20c
0020C1B3 20302823            // 02c xor / sw 0x210
0020E1B3 20302A23            // 034 or / sw 0x214
0020F1B3 20302C23            // 03c and / sw 0x218
06410193 20302E23            // 044 addi x3,x2,100 / sw 0x21c
00500013 22002023            // 04c addi x0,x0,5 / sw x0,0x220
000091B3 22302223            // 054 sll x3,x1,x0 / sw 0x224
00109193 22302423            // 05c slli x3,x1,1 / sw 0x228
01F11193 22302623            // 064 slli x3,x2,31 / sw 0x22c
0010D193 22302823            // 06c srli x3,x1,1 / sw 0x230
01F0D193 22302A23            // 074 srli x3,x1,31 / sw 0x234
4010D193 22302C23            // 07c srai x3,x1,1 / sw 0x238
41F0D193 22302E23            // 084 srai x3,x1,31 / sw 0x23c
123451B7 24302023            // 08c lui x3,0x12345 / sw 0x240
00001197 24302223            // 094 auipc x3,1 / sw 0x244
008002EF 7FE02E23 24502423   // 09c jal x5,+8 / poison / sw x5,0x248
0B000367 7FE02E23 24602623   // 0a8 jalr x6,0xb0(x0) / poison / sw x6,0x24c
00210463 7FE02E23 04208C63   // 0b4 beq taken / poison / beq not taken
00209463 7FE02E23 04211663   // 0c0 bne taken / poison / bne not taken
0020C463 7FE02E23 04114063   // 0cc blt taken / poison / blt not taken
00115463 7FE02E23 0220DA63   // 0d8 bge taken / poison / bge not taken
00116463 7FE02E23 0220E463   // 0e4 bltu taken / poison / bltu not taken
0020F463 7FE02E23 00117E63   // 0f0 bgeu taken / poison / bgeu not taken
30102023 30002203 24402823   // 0fc sw x1,0x300 / lw x4,0x300 / sw x4,0x250
30802203 24402A23 0000006F   // 108 lw x4,0x308 / sw x4,0x254 / jal x0,0 end
7FE02E23 0000006F            // 114 poison target sw x30,0x7fc / jal x0,0
@c2
13579BDF                     // 308 preloaded data word

// File: testbench/tbCore.sv
`include "coreConfig_config.svh"

module tbCore;
   import rvCorePkg::*;

   localparam int NUM_INSTR      = 71;               // words of program.hex code
   localparam int TIMEOUT_CYCLES = NUM_INSTR * 40;  // longest shift plus stalls
   localparam int NUM_STORES     = 23;
   localparam int RESET_CYCLES   = 4;

   logic        clk;
   logic        reset;
   memReq_t     memReq;
   logic [31:0] rdata;
   logic        rbusy;
   logic        wbusy;

   logic [31:0] expAddr [NUM_STORES];
   logic [31:0] expData [NUM_STORES];
   int          cycles;
   int          storeCount;
   int          tests;
   int          errors;
   int          resetErrors;
   bit          fetchSeen;

   femtoCore dut (
      .clk(clk), .reset(reset), .memReq(memReq),
      .rdata(rdata), .rbusy(rbusy), .wbusy(wbusy)
   );

   tbMemory memory (
      .clk(clk), .reset(reset), .memReq(memReq),
      .rdata(rdata), .rbusy(rbusy), .wbusy(wbusy)
   );

   task automatic addExpect(input int idx, input logic [31:0] a, input logic [31:0] d);
      expAddr[idx] = a;
      expData[idx] = d;
   endtask

   // counts line, verdict, end of simulation
   task automatic finishRun();
      $display("tests run %0d, failures %0d", tests, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   endtask

   // ************************************************************
   // clock, reset, expected store table
   // ************************************************************
   initial clk = 1'b0;
   always #20 clk = ~clk;

   initial begin
      cycles      = 0;
      storeCount  = 0;
      tests       = 0;
      errors      = 0;
      resetErrors = 0;
      fetchSeen   = 1'b0;
      reset       = 1'b0;
      addExpect(0,  32'h200, 32'hffff_fffe);  // add  -5 + 3
      addExpect(1,  32'h204, 32'hffff_fff8);  // sub  -5 - 3
      addExpect(2,  32'h208, 32'h0000_0001);  // slt  -5 < 3 signed
      addExpect(3,  32'h20c, 32'h0000_0000);  // sltu 0xfffffffb < 3 unsigned fails
      addExpect(4,  32'h210, 32'hffff_fff8);  // xor
      addExpect(5,  32'h214, 32'hffff_fffb);  // or
      addExpect(6,  32'h218, 32'h0000_0003);  // and
      addExpect(7,  32'h21c, 32'h0000_0067);  // addi 3 + 100
      addExpect(8,  32'h220, 32'h0000_0000);  // x0 after addi x0, x0, 5
      addExpect(9,  32'h224, 32'hffff_fffb);  // sll by 0
      addExpect(10, 32'h228, 32'hffff_fff6);  // slli by 1
      addExpect(11, 32'h22c, 32'h8000_0000);  // slli 3 by 31
      addExpect(12, 32'h230, 32'h7fff_fffd);  // srli by 1, zero fill
      addExpect(13, 32'h234, 32'h0000_0001);  // srli by 31
      addExpect(14, 32'h238, 32'hffff_fffd);  // srai by 1, sign fill
      addExpect(15, 32'h23c, 32'hffff_ffff);  // srai by 31
      addExpect(16, 32'h240, 32'h1234_5000);  // lui 0x12345
      addExpect(17, 32'h244, 32'h0000_1094);  // auipc 1 at 0x94
      addExpect(18, 32'h248, 32'h0000_00a0);  // jal link, jal at 0x9c
      addExpect(19, 32'h24c, 32'h0000_00ac);  // jalr link, jalr at 0xa8
      addExpect(20, 32'h300, 32'hffff_fffb);  // sw x1 into the data area
      addExpect(21, 32'h250, 32'hffff_fffb);  // lw of that word
      addExpect(22, 32'h254, 32'h1357_9bdf);  // lw of the preloaded word
      repeat (RESET_CYCLES) @(posedge clk);
      #2 reset = 1'b1;
   end

   // cycle count and timeout
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout: only %0d of %0d stores seen after %0d cycles",
                  storeCount, NUM_STORES, cycles);
         errors = errors + 1;
         finishRun();
      end
   end

   // ************************************************************
   // checks on the falling edge, where the bus is stable
   // ************************************************************
   always @(negedge clk) begin
      // reset and the cycle after it, from the first edge on
      if (cycles >= 1 && cycles <= RESET_CYCLES + 1) begin
         assert (memReq.wmask === 4'b0000) else begin
            $display("ERR t=%0t memReq.wmask expected 0000 got %b", $time, memReq.wmask);
            resetErrors = resetErrors + 1;
         end
         // first fetch strobe is due on the cycle after reset
         if (cycles <= RESET_CYCLES) begin
            assert (memReq.rstrb === 1'b0) else begin
               $display("ERR t=%0t memReq.rstrb expected 0 got %b", $time, memReq.rstrb);
               resetErrors = resetErrors + 1;
            end
         end
         if (cycles == RESET_CYCLES + 1) begin
            tests  = tests + 1;
            errors = errors + resetErrors;
            $display("reset: bus idle %s", (resetErrors == 0) ? "ok" : "failed");
         end
      end
      if (reset && memReq.rstrb && !fetchSeen) begin
         fetchSeen = 1'b1;
         tests     = tests + 1;
         assert (memReq.addr == `RESET_ADDR) else begin
            $display("ERR t=%0t memReq.addr expected %h got %h", $time, `RESET_ADDR,
                     memReq.addr);
            errors = errors + 1;
         end
         $display("first fetch at %h", memReq.addr);
      end
      if (reset && memReq.wmask != 4'b0000) begin
         tests = tests + 1;
         assert (memReq.addr == expAddr[storeCount]) else begin
            $display("ERR t=%0t memReq.addr expected %h got %h", $time,
                     expAddr[storeCount], memReq.addr);
            errors = errors + 1;
         end
         assert (memReq.wdata == expData[storeCount]) else begin
            $display("ERR t=%0t memReq.wdata expected %h got %h", $time,
                     expData[storeCount], memReq.wdata);
            errors = errors + 1;
         end
         assert (memReq.wmask == 4'b1111) else begin
            $display("ERR t=%0t memReq.wmask expected 1111 got %b", $time, memReq.wmask);
            errors = errors + 1;
         end
         $display("store %0d: addr %h data %h", storeCount, memReq.addr, memReq.wdata);
         storeCount = storeCount + 1;
         if (storeCount == NUM_STORES) begin
            finishRun();
         end
      end
   end

endmodule

// File: testbench/tbMemory.sv
module tbMemory (
   input  logic               clk,
   input  logic               reset,
   input  rvCorePkg::memReq_t memReq,
   output logic [31:0]        rdata,
   output logic               rbusy,
   output logic               wbusy
);
   import rvCorePkg::*;

   localparam int WORDS = 1024;  // 4 KB, word index from addr bits 11..2

   logic [31:0] mem [WORDS];
   logic [31:0] readWord;     // word of the last read, held until the next one
   integer      seed;
   int          readStall;    // cycles rbusy still stays high
   int          writeStall;

   initial begin
      seed       = 32'h64c5;
      readWord   = 32'h0;
      readStall  = 0;
      writeStall = 0;
      rdata      = 32'h0;
      rbusy      = 1'b0;
      wbusy      = 1'b0;
      for (int i = 0; i < WORDS; i++) begin
         mem[i] = 32'hfee0_0000 | i;  // unloaded words show their own index
      end
      $readmemh("testbench/program.hex", mem);
   end

   // ************************************************************
   // sample the request on the edge, answer 2 units later
   // ************************************************************
   always @(posedge clk) begin
      if (reset && memReq.rstrb) begin
         readWord  = mem[memReq.addr[11:2]];
         readStall = $random(seed) & 3;  // 0 to 3 busy cycles
      end else if (readStall != 0) begin
         readStall = readStall - 1;
      end
      if (reset && memReq.wmask != 4'b0000) begin
         for (int b = 0; b < 4; b++) begin
            if (memReq.wmask[b]) begin
               mem[memReq.addr[11:2]][8*b +: 8] = memReq.wdata[8*b +: 8];  // byte lane b
            end
         end
         writeStall = $random(seed) & 3;
      end else if (writeStall != 0) begin
         writeStall = writeStall - 1;
      end
      #2;
      rdata = readWord;
      rbusy = (readStall != 0);
      wbusy = (writeStall != 0);
   end

endmodule
